/* common/riscDefs.svh */
`ifndef RISC_DEFS_SVH
`define RISC_DEFS_SVH

// --------------------------------------------------
// machine word and register file geometry
// --------------------------------------------------
`define DATA_W 14          // scalar word
`define LANE_W 7           // one vector lane, two per word
`define REG_N  16
`define ADDR_W 4

// instruction word fields
`define OPC_HI 13
`define OPC_LO 8
`define RA_HI  7           // destination and first source
`define RA_LO  4
`define RB_HI  3           // second source, constant or shift count
`define RB_LO  0

// --------------------------------------------------
// opcodes
// --------------------------------------------------
`define OP_NOP  6'h00
`define OP_CPY  6'h03

`define OP_ADD  6'h20
`define OP_SUB  6'h21
`define OP_ADDC 6'h22      // rb field used as 4-bit constant
`define OP_SUBC 6'h23

`define OP_NOT  6'h28
`define OP_AND  6'h29
`define OP_OR   6'h2A
`define OP_XOR  6'h2B

`define OP_SHLL 6'h2C
`define OP_SHRL 6'h2D
`define OP_SHLA 6'h2E
`define OP_SHRA 6'h2F
`define OP_ROTL 6'h30
`define OP_ROTR 6'h31

`define OP_ADDV 6'h38      // two independent 7-bit lanes
`define OP_SUBV 6'h39

// bit positions inside a flag nibble
`define FLG_Z 0
`define FLG_V 1
`define FLG_N 2
`define FLG_C 3

`endif

/* common/riscPkg.sv */
`include "riscDefs.svh"

package riscPkg;

    // --------------------------------------------------
    // one operand word, seen either whole or as two lanes
    // --------------------------------------------------
    typedef struct packed {
        logic [`LANE_W-1:0] hi;     // bits 13..7
        logic [`LANE_W-1:0] lo;     // bits 6..0
    } lanePair_s;

    typedef union packed {
        logic [`DATA_W-1:0] word;   // scalar view
        lanePair_s          lane;   // ADDV / SUBV view
    } laneWord_u;

endpackage

/* source/operandFetch.sv */
`timescale 1ns/1ps
`include "riscDefs.svh"

module operandFetch (
    input  logic                     Clock_pin,
    input  logic                     rst,
    input  logic                     instValid,
    input  logic [`DATA_W-1:0]       instWord,
    input  logic                     commitValid,
    input  logic [`ADDR_W-1:0]       commitAddr,
    input  logic [`DATA_W-1:0]       commitData,
    output riscPkg::laneWord_u       opA,
    output riscPkg::laneWord_u       opB,
    output logic [`OPC_HI-`OPC_LO:0] opCode,
    output logic [`ADDR_W-1:0]       shAmt,
    output logic [`ADDR_W-1:0]       dest
);

    logic [`DATA_W-1:0]       regFile [`REG_N];
    logic [`OPC_HI-`OPC_LO:0] instOpc;
    logic [`ADDR_W-1:0]       raIdx;
    logic [`ADDR_W-1:0]       rbIdx;
    logic [`DATA_W-1:0]       raVal;
    logic [`DATA_W-1:0]       rbVal;
    logic [`DATA_W-1:0]       bSel;
    logic                     useConst;

    // --------------------------------------------------
    // decode and register read with bypass
    // --------------------------------------------------
    assign instOpc = instWord[`OPC_HI:`OPC_LO];
    assign raIdx   = instWord[`RA_HI:`RA_LO];
    assign rbIdx   = instWord[`RB_HI:`RB_LO];

    // the instruction in execute writes at the same edge we sample
    assign raVal = (commitValid && (commitAddr == raIdx)) ? commitData : regFile[raIdx];
    assign rbVal = (commitValid && (commitAddr == rbIdx)) ? commitData : regFile[rbIdx];

    assign useConst = (instOpc == `OP_ADDC) || (instOpc == `OP_SUBC);
    assign bSel     = useConst ? {{(`DATA_W-`ADDR_W){1'b0}}, rbIdx} : rbVal;  // zero-extended

    // --------------------------------------------------
    // register file, written from the merge stage
    // --------------------------------------------------
    always_ff @(posedge Clock_pin) begin
        if (rst) begin
            for (int i = 0; i < `REG_N; i++) begin
                regFile[i] <= '0;               // machine starts from all zeros
            end
        end else if (commitValid) begin
            regFile[commitAddr] <= commitData;
        end
    end

    // gaps in the strobe become bubbles
    always_ff @(posedge Clock_pin) begin
        if (rst) begin
            opCode <= `OP_NOP;
        end else if (instValid) begin
            opCode <= instOpc;
        end else begin
            opCode <= `OP_NOP;
        end
    end

    // operand registers, only meaningful with a live opcode
    always_ff @(posedge Clock_pin) begin
        if (instValid) begin
            opA.word <= raVal;
            opB.word <= bSel;
            shAmt    <= rbIdx;                 // shift and rotate count
            dest     <= raIdx;
        end
    end

endmodule

/* execute/scalarAlu.sv */
`timescale 1ns/1ps
`include "riscDefs.svh"

module scalarAlu (
    input  riscPkg::laneWord_u       opA,
    input  riscPkg::laneWord_u       opB,
    input  logic [`OPC_HI-`OPC_LO:0] opCode,
    input  logic [`ADDR_W-1:0]       shAmt,
    output logic [`DATA_W-1:0]       scalarRes,
    output logic [3:0]               scalarFlags
);

    logic                   isSub;
    logic [`DATA_W-1:0]     bEff;
    logic [`DATA_W:0]       addWide;
    logic [`ADDR_W-1:0]     rotAmt;
    logic [2*`DATA_W-1:0]   rotLeft;
    logic [2*`DATA_W-1:0]   rotRight;

    // --------------------------------------------------
    // adder, subtract as A + ~B + 1
    // --------------------------------------------------
    assign isSub   = (opCode == `OP_SUB) || (opCode == `OP_SUBC);
    assign bEff    = isSub ? ~opB.word : opB.word;
    assign addWide = {1'b0, opA.word} + {1'b0, bEff} + (`DATA_W+1)'(isSub);

    // --------------------------------------------------
    // rotates by count mod 14, via a doubled word
    // --------------------------------------------------
    assign rotAmt   = (shAmt >= 4'd14) ? (shAmt - 4'd14) : shAmt;
    assign rotLeft  = {opA.word, opA.word} << rotAmt;
    assign rotRight = {opA.word, opA.word} >> rotAmt;

    always_comb begin
        scalarRes   = opA.word;
        scalarFlags = '0;

        case (opCode)
            `OP_ADD, `OP_SUB, `OP_ADDC, `OP_SUBC: begin
                scalarRes             = addWide[`DATA_W-1:0];
                scalarFlags[`FLG_C]   = addWide[`DATA_W];     // carry out, no borrow inversion
                scalarFlags[`FLG_V]   = (opA.word[`DATA_W-1] == bEff[`DATA_W-1]) &&
                                        (addWide[`DATA_W-1] != opA.word[`DATA_W-1]);
            end

            `OP_NOT: begin
                scalarRes = ~opA.word;
            end
            `OP_AND: begin
                scalarRes = opA.word & opB.word;
            end
            `OP_OR: begin
                scalarRes = opA.word | opB.word;
            end
            `OP_XOR: begin
                scalarRes = opA.word ^ opB.word;
            end

            // counts past the word width fall out as zero
            `OP_SHLL, `OP_SHLA: begin
                scalarRes = opA.word << shAmt;         // arithmetic left same as logical
            end
            `OP_SHRL: begin
                scalarRes = opA.word >> shAmt;
            end
            `OP_SHRA: begin
                scalarRes = $signed(opA.word) >>> shAmt;   // saturates to sign bits
            end

            `OP_ROTL: begin
                scalarRes = rotLeft[2*`DATA_W-1:`DATA_W];
            end
            `OP_ROTR: begin
                scalarRes = rotRight[`DATA_W-1:0];
            end

            default: begin
                scalarRes = opA.word;                  // not a scalar op
            end
        endcase

        // Z and N come from the result for every op; merge decides which ops keep them
        scalarFlags[`FLG_Z] = (scalarRes == '0);
        scalarFlags[`FLG_N] = scalarRes[`DATA_W-1];
    end

endmodule

/* execute/laneAlu.sv */
`timescale 1ns/1ps
`include "riscDefs.svh"

module laneAlu (
    input  riscPkg::laneWord_u       opA,
    input  riscPkg::laneWord_u       opB,
    input  logic [`OPC_HI-`OPC_LO:0] opCode,
    output riscPkg::laneWord_u       laneRes,
    output logic [3:0]               hiFlags,
    output logic [3:0]               loFlags
);

    logic               laneSub;
    logic [`LANE_W+3:0] hiOut;     // {flags, sum}
    logic [`LANE_W+3:0] loOut;

    // one lane add/sub, returns flag nibble over the lane sum
    function automatic logic [`LANE_W+3:0] laneAddSub(
        input logic [`LANE_W-1:0] a,
        input logic [`LANE_W-1:0] b,
        input logic               sub
    );
        logic [`LANE_W-1:0] bEff;
        logic [`LANE_W:0]   wide;
        logic [3:0]         flg;
        bEff = sub ? ~b : b;
        wide = {1'b0, a} + {1'b0, bEff} + (`LANE_W+1)'(sub);
        flg  = '0;                                   // N stays clear for lanes
        flg[`FLG_Z] = (wide[`LANE_W-1:0] == '0);
        flg[`FLG_V] = (a[`LANE_W-1] == bEff[`LANE_W-1]) && (wide[`LANE_W-1] != a[`LANE_W-1]);
        flg[`FLG_C] = wide[`LANE_W];
        return {flg, wide[`LANE_W-1:0]};
    endfunction

    assign laneSub = (opCode == `OP_SUBV);

    // no carry crosses from lo into hi
    assign hiOut = laneAddSub(opA.lane.hi, opB.lane.hi, laneSub);
    assign loOut = laneAddSub(opA.lane.lo, opB.lane.lo, laneSub);

    assign laneRes.lane.hi = hiOut[`LANE_W-1:0];
    assign laneRes.lane.lo = loOut[`LANE_W-1:0];
    assign hiFlags         = hiOut[`LANE_W+3:`LANE_W];
    assign loFlags         = loOut[`LANE_W+3:`LANE_W];

endmodule

/* execute/resultMerge.sv */
`timescale 1ns/1ps
`include "riscDefs.svh"

module resultMerge (
    input  logic                     Clock_pin,
    input  logic                     rst,
    input  logic [`OPC_HI-`OPC_LO:0] opCode,
    input  logic [`ADDR_W-1:0]       dest,
    input  riscPkg::laneWord_u       opB,
    input  logic [`DATA_W-1:0]       scalarRes,
    input  logic [3:0]               scalarFlags,
    input  riscPkg::laneWord_u       laneRes,
    input  logic [3:0]               hiFlags,
    input  logic [3:0]               loFlags,
    output logic                     commitValid,
    output logic [`ADDR_W-1:0]       commitAddr,
    output logic [`DATA_W-1:0]       commitData,
    output logic                     wbValid,
    output logic [`ADDR_W-1:0]       wbAddr,
    output logic [`DATA_W-1:0]       wbData,
    output logic [7:0]               statusFlags
);

    logic updScalar;     // arithmetic and logic touch the upper nibble
    logic updLane;       // lane ops touch both nibbles

    // --------------------------------------------------
    // result select and write decision
    // --------------------------------------------------
    always_comb begin
        commitValid = 1'b1;
        commitData  = scalarRes;
        updScalar   = 1'b0;
        updLane     = 1'b0;
        case (opCode)
            `OP_CPY: commitData = opB.word;                 // flags kept
            `OP_ADD, `OP_SUB, `OP_ADDC, `OP_SUBC,
            `OP_NOT, `OP_AND, `OP_OR, `OP_XOR: updScalar = 1'b1;
            `OP_SHLL, `OP_SHRL, `OP_SHLA, `OP_SHRA,
            `OP_ROTL, `OP_ROTR: updScalar = 1'b0;           // shifts keep every flag
            `OP_ADDV, `OP_SUBV: begin
                commitData = laneRes.word;
                updLane    = 1'b1;
            end
            default: commitValid = 1'b0;                    // NOP and unknown codes
        endcase
    end

    assign commitAddr = dest;

    always_ff @(posedge Clock_pin) begin
        if (rst) begin
            wbValid     <= 1'b0;
            statusFlags <= '0;
        end else begin
            wbValid <= commitValid;
            if (updLane) begin
                statusFlags <= {hiFlags, loFlags};
            end else if (updScalar) begin
                statusFlags[7:4] <= scalarFlags;            // lower nibble kept
            end
        end
    end

    // write-back echo holds its last value between writes
    always_ff @(posedge Clock_pin) begin
        if (commitValid) begin
            wbAddr <= commitAddr;
            wbData <= commitData;
        end
    end

endmodule

/* source/execCluster.sv */
`timescale 1ns/1ps
`include "riscDefs.svh"

module execCluster (
    input  logic               Clock_pin,
    input  logic               rst,
    input  logic               instValid,
    input  logic [`DATA_W-1:0] instWord,
    output logic               wbValid,
    output logic [`ADDR_W-1:0] wbAddr,
    output logic [`DATA_W-1:0] wbData,
    output logic [7:0]         statusFlags
);

    import riscPkg::*;

    laneWord_u                opA;
    laneWord_u                opB;
    laneWord_u                laneRes;
    logic [`OPC_HI-`OPC_LO:0] opCode;
    logic [`ADDR_W-1:0]       shAmt;
    logic [`ADDR_W-1:0]       dest;
    logic [`DATA_W-1:0]       scalarRes;
    logic [3:0]               scalarFlags;
    logic [3:0]               hiFlags;
    logic [3:0]               loFlags;
    logic                     commitValid;   // same-cycle feedback to the register file
    logic [`ADDR_W-1:0]       commitAddr;
    logic [`DATA_W-1:0]       commitData;

    // --------------------------------------------------
    // operand stage, two parallel ALUs, merge stage
    // --------------------------------------------------
    operandFetch uFetch (
        .Clock_pin   (Clock_pin),
        .rst         (rst),
        .instValid   (instValid),
        .instWord    (instWord),
        .commitValid (commitValid),
        .commitAddr  (commitAddr),
        .commitData  (commitData),
        .opA         (opA),
        .opB         (opB),
        .opCode      (opCode),
        .shAmt       (shAmt),
        .dest        (dest)
    );

    scalarAlu uScalar (
        .opA         (opA),
        .opB         (opB),
        .opCode      (opCode),
        .shAmt       (shAmt),
        .scalarRes   (scalarRes),
        .scalarFlags (scalarFlags)
    );

    laneAlu uLane (
        .opA     (opA),
        .opB     (opB),
        .opCode  (opCode),
        .laneRes (laneRes),
        .hiFlags (hiFlags),
        .loFlags (loFlags)
    );

    resultMerge uMerge (
        .Clock_pin   (Clock_pin),
        .rst         (rst),
        .opCode      (opCode),
        .dest        (dest),
        .opB         (opB),
        .scalarRes   (scalarRes),
        .scalarFlags (scalarFlags),
        .laneRes     (laneRes),
        .hiFlags     (hiFlags),
        .loFlags     (loFlags),
        .commitValid (commitValid),
        .commitAddr  (commitAddr),
        .commitData  (commitData),
        .wbValid     (wbValid),
        .wbAddr      (wbAddr),
        .wbData      (wbData),
        .statusFlags (statusFlags)
    );

endmodule

/* bench/cluster_asserts.sv */
`timescale 1ns/1ps

module cluster_asserts (
    input logic       Clock_pin,
    input logic       rst,
    input logic       instValid,
    input logic       wbValid,
    input logic [7:0] statusFlags
);

    int failCount = 0;

    // --------------------------------------------------
    // write-back protocol
    // --------------------------------------------------
    wbQuietAfterReset: assert property (@(posedge Clock_pin) rst |=> !wbValid)
        else begin
            failCount++;
            $error("wbValid high in the cycle after reset");
        end

    wbNeedsInstruction: assert property (@(posedge Clock_pin) disable iff (rst)
            wbValid |-> $past(instValid, 2))
        else begin
            failCount++;
            $error("wbValid without an instruction two cycles earlier");
        end

    flagsHoldWithoutWrite: assert property (@(posedge Clock_pin) disable iff (rst)
            !wbValid |-> $stable(statusFlags))
        else begin
            failCount++;
            $error("statusFlags changed without a register write");
        end

endmodule

bind execCluster cluster_asserts uAsserts (
    .Clock_pin   (Clock_pin),
    .rst         (rst),
    .instValid   (instValid),
    .wbValid     (wbValid),
    .statusFlags (statusFlags)
);

/* bench/clusterChecker.sv */
`timescale 1ns/1ps
`include "riscDefs.svh"

module clusterChecker (
    input logic               Clock_pin,
    input logic               rst,
    input logic               instValid,
    input logic [`DATA_W-1:0] instWord,
    input logic               wbValid,
    input logic [`ADDR_W-1:0] wbAddr,
    input logic [`DATA_W-1:0] wbData,
    input logic [7:0]         statusFlags
);

    logic [13:0] model [16];
    logic [7:0]  flags;
    logic [26:0] pipe1;          // {valid, addr, data, flags}, one edge old
    logic [26:0] pipe2;          // two edges old, due now
    string       testName = "none";
    int          checks = 0;
    int          errors = 0;
    int          phaseChecks = 0;
    int          phaseErrors = 0;

    function automatic logic [3:0] nibble(input logic z, input logic v,
                                          input logic n, input logic c);
        logic [3:0] f;
        f = 4'h0;
        f[`FLG_Z] = z;
        f[`FLG_V] = v;
        f[`FLG_N] = n;
        f[`FLG_C] = c;
        return f;
    endfunction

    // w-bit add or subtract, returns {C, V, result}
    function automatic logic [15:0] addSub(input logic [13:0] a, input logic [13:0] b,
                                           input int w, input logic sub);
        logic [14:0] full;
        logic [13:0] res;
        logic        c;
        logic        v;
        full = sub ? ({1'b0, a} - {1'b0, b}) : ({1'b0, a} + {1'b0, b});
        res  = full[13:0] & ((w == 14) ? 14'h3FFF : 14'h007F);
        c    = sub ? (a >= b) : full[w];      // no borrow means carry set
        if (sub) begin
            v = (a[w-1] != b[w-1]) && (res[w-1] != a[w-1]);
        end else begin
            v = (a[w-1] == b[w-1]) && (res[w-1] != a[w-1]);
        end
        return {c, v, res};
    endfunction

    function automatic logic [13:0] shiftRot(input logic [5:0] op, input logic [13:0] a,
                                             input logic [3:0] n);
        logic [13:0] r;
        r = a;
        case (op)
            `OP_SHLL, `OP_SHLA: r = (n >= 14) ? 14'h0 : a << n;
            `OP_SHRL: r = (n >= 14) ? 14'h0 : a >> n;
            `OP_SHRA: repeat (n) r = {r[13], r[13:1]};
            `OP_ROTL: repeat (n % 14) r = {r[12:0], r[13]};
            default: repeat (n % 14) r = {r[0], r[13:1]};
        endcase
        return r;
    endfunction

    // --------------------------------------------------
    // model step, register file and flags in program order
    // --------------------------------------------------
    task automatic predict(input logic [13:0] w, output logic [26:0] ent);
        logic [5:0]  op;
        logic [13:0] a;
        logic [13:0] b;
        logic [13:0] res;
        logic [15:0] s;
        logic [15:0] hi;
        logic [15:0] lo;
        logic        wr;
        op  = w[13:8];
        a   = model[w[7:4]];
        b   = (op == `OP_ADDC || op == `OP_SUBC) ? {10'h0, w[3:0]} : model[w[3:0]];
        wr  = 1'b1;
        res = 14'h0;
        case (op)
            `OP_CPY: res = b;
            `OP_ADD, `OP_SUB, `OP_ADDC, `OP_SUBC: begin
                s   = addSub(a, b, 14, op == `OP_SUB || op == `OP_SUBC);
                res = s[13:0];
                flags[7:4] = nibble(res == 0, s[14], res[13], s[15]);
            end
            `OP_NOT, `OP_AND, `OP_OR, `OP_XOR: begin
                res = (op == `OP_NOT) ? ~a : (op == `OP_AND) ? (a & b) :
                      (op == `OP_OR) ? (a | b) : (a ^ b);
                flags[7:4] = nibble(res == 0, 1'b0, res[13], 1'b0);
            end
            `OP_SHLL, `OP_SHRL, `OP_SHLA, `OP_SHRA, `OP_ROTL, `OP_ROTR: begin
                res = shiftRot(op, a, w[3:0]);    // flags untouched
            end
            `OP_ADDV, `OP_SUBV: begin
                hi  = addSub({7'h0, a[13:7]}, {7'h0, b[13:7]}, 7, op == `OP_SUBV);
                lo  = addSub({7'h0, a[6:0]}, {7'h0, b[6:0]}, 7, op == `OP_SUBV);
                res = {hi[6:0], lo[6:0]};
                flags = {nibble(hi[6:0] == 0, hi[14], 1'b0, hi[15]),
                         nibble(lo[6:0] == 0, lo[14], 1'b0, lo[15])};
            end
            default: wr = 1'b0;
        endcase
        if (wr) begin
            model[w[7:4]] = res;
        end
        ent = {wr, w[7:4], res, flags};
    endtask

    task automatic compare(input string field, input logic [13:0] exp, input logic [13:0] act);
        checks++;
        phaseChecks++;
        if (act !== exp) begin
            errors++;
            phaseErrors++;
            $display("Mismatch test=%s %s expected=%h actual=%h", testName, field, exp, act);
        end
    endtask

    task automatic startPhase(input string name);
        testName    = name;
        phaseChecks = 0;
        phaseErrors = 0;
    endtask

    task automatic endPhase();
        $display("test %s: %0d checks, %0d errors, %s", testName, phaseChecks, phaseErrors,
                 (phaseErrors == 0) ? "ok" : "failed");
    endtask

    always @(posedge Clock_pin) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                model[i] = 14'h0;
            end
            flags = 8'h0;
            pipe1 = 27'h0;
            pipe2 = 27'h0;
        end else begin
            compare("wbValid", {13'h0, pipe2[26]}, {13'h0, wbValid});
            compare("statusFlags", {6'h0, pipe2[7:0]}, {6'h0, statusFlags});
            if (pipe2[26]) begin
                compare("wbAddr", {10'h0, pipe2[25:22]}, {10'h0, wbAddr});
                compare("wbData", pipe2[21:8], wbData);
            end
            pipe2 = pipe1;
            if (instValid) begin
                predict(instWord, pipe1);
            end else begin
                pipe1 = {19'h0, flags};           // bubble
            end
        end
    end

endmodule

/* bench/clusterTb.sv */
`timescale 1ns/1ps
`include "riscDefs.svh"

module clusterTb;

    localparam int RESET_CYC = 4;
    localparam int DRAIN     = 4;
    localparam int N_IDLE    = 24;
    localparam int N_RAND    = 150;               // arith, logic, lane and forwarding phases
    localparam int N_SHIFT   = 6 * 16 * 2;        // refresh plus shift for every count
    localparam int LIMIT     = RESET_CYC + 2 * (N_IDLE + 4 * N_RAND + N_SHIFT) + 6 * DRAIN + 200;

    logic               Clock_pin;
    logic               rst;
    logic               instValid;
    logic [`DATA_W-1:0] instWord;
    logic               wbValid;
    logic [`ADDR_W-1:0] wbAddr;
    logic [`DATA_W-1:0] wbData;
    logic [7:0]         statusFlags;
    integer             seed;
    int                 cycles = 0;
    int                 assertFails;

    logic [5:0] arithOps [4] = '{`OP_ADD, `OP_SUB, `OP_ADDC, `OP_SUBC};
    logic [5:0] logicOps [7] = '{`OP_NOT, `OP_AND, `OP_OR, `OP_XOR, `OP_CPY, `OP_ADDC, `OP_SUBC};
    logic [5:0] shiftOps [6] = '{`OP_SHLL, `OP_SHRL, `OP_SHLA, `OP_SHRA, `OP_ROTL, `OP_ROTR};
    logic [5:0] laneOps  [6] = '{`OP_ADDV, `OP_SUBV, `OP_ADDV, `OP_SUBV, `OP_ADDC, `OP_ROTL};
    logic [5:0] oddOps   [6] = '{`OP_NOP, 6'h01, 6'h10, 6'h24, 6'h32, 6'h3F};  // no writes

    execCluster uut (
        .Clock_pin   (Clock_pin),
        .rst         (rst),
        .instValid   (instValid),
        .instWord    (instWord),
        .wbValid     (wbValid),
        .wbAddr      (wbAddr),
        .wbData      (wbData),
        .statusFlags (statusFlags)
    );

    clusterChecker chk (
        .Clock_pin   (Clock_pin),
        .rst         (rst),
        .instValid   (instValid),
        .instWord    (instWord),
        .wbValid     (wbValid),
        .wbAddr      (wbAddr),
        .wbData      (wbData),
        .statusFlags (statusFlags)
    );

    initial begin
        Clock_pin = 1'b0;
        forever #2 Clock_pin = ~Clock_pin;
    end

    function automatic int randBelow(input int n);
        int unsigned u;
        u = $random(seed);
        return u % n;
    endfunction

    function automatic logic [5:0] pickOp(input int group);
        int g;
        g = (group > 3) ? randBelow(5) : group;   // group 4 mixes everything
        case (g)
            0: return oddOps[randBelow(6)];
            1: return arithOps[randBelow(4)];
            2: return logicOps[randBelow(7)];
            3: return laneOps[randBelow(6)];
            default: return shiftOps[randBelow(6)];
        endcase
    endfunction

    // --------------------------------------------------
    // drive tasks
    // --------------------------------------------------
    task automatic issue(input logic [5:0] op, input logic [3:0] ra, input logic [3:0] rb);
        @(posedge Clock_pin);
        instValid <= 1'b1;
        instWord  <= {op, ra, rb};
    endtask

    task automatic bubble();
        @(posedge Clock_pin);
        instValid <= 1'b0;
        instWord  <= 14'(randBelow(16384));       // junk that must be ignored
    endtask

    task automatic runRandom(input string name, input int group, input int n,
                             input bit gaps, input bit chain);
        logic [3:0] last;
        logic [3:0] ra;
        logic [3:0] rb;
        last = 4'h0;
        chk.startPhase(name);
        repeat (n) begin
            if (gaps && randBelow(8) == 0) begin
                bubble();
            end
            ra = (chain && randBelow(2) == 0) ? last : 4'(randBelow(16));
            rb = (chain && randBelow(2) == 0) ? last : 4'(randBelow(16));
            issue(pickOp(group), ra, rb);
            last = ra;                            // next one leans on this dest
        end
        repeat (DRAIN) bubble();
        @(negedge Clock_pin);
        chk.endPhase();
    endtask

    task automatic runShifts();
        logic [3:0] d;
        chk.startPhase("shiftRot");
        for (int s = 0; s < 6; s++) begin
            for (int n = 0; n < 16; n++) begin
                d = 4'(randBelow(16));
                issue(arithOps[randBelow(4)], d, 4'(randBelow(16)));  // fresh value and flags
                issue(shiftOps[s], d, 4'(n));
            end
        end
        repeat (DRAIN) bubble();
        @(negedge Clock_pin);
        chk.endPhase();
    endtask

    // --------------------------------------------------
    // run limit
    // --------------------------------------------------
    always @(posedge Clock_pin) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        seed      = 32'haee0_13d7;
        rst       = 1'b1;
        instValid = 1'b0;
        instWord  = '0;
        repeat (RESET_CYC) @(posedge Clock_pin);
        rst <= 1'b0;

        runRandom("resetIdle", 0, N_IDLE, 1'b1, 1'b0);
        runRandom("arith", 1, N_RAND, 1'b1, 1'b0);
        runRandom("logicCpy", 2, N_RAND, 1'b1, 1'b0);
        runShifts();
        runRandom("lanes", 3, N_RAND, 1'b1, 1'b0);
        runRandom("forward", 4, N_RAND, 1'b0, 1'b1);   // back to back and dependent

        assertFails = uut.uAsserts.failCount;
        $display("summary: %0d checks, %0d mismatches, %0d assertion failures",
                 chk.checks, chk.errors, assertFails);
        if (chk.errors == 0 && assertFails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+common
common/riscPkg.sv
source/operandFetch.sv
execute/scalarAlu.sv
execute/laneAlu.sv
execute/resultMerge.sv
source/execCluster.sv
bench/cluster_asserts.sv
bench/clusterChecker.sv
bench/clusterTb.sv

/* Bender.yml */
package:
  name: exec_cluster

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/riscPkg.sv
      - source/operandFetch.sv
      - execute/scalarAlu.sv
      - execute/laneAlu.sv
      - execute/resultMerge.sv
      - source/execCluster.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - bench/cluster_asserts.sv
      - bench/clusterChecker.sv
      - bench/clusterTb.sv
